/* source/pokey_pkg.sv */
package pokey_pkg;

	localparam int ADDR_W = 4; // register address bits
	localparam int DATA_W = 8; // every register is one byte

	// register map, pots sit at the bottom so the address is the pot number
	localparam logic [ADDR_W-1:0] POT0_ADDR   = 4'd0;
	localparam logic [ADDR_W-1:0] POT1_ADDR   = 4'd1;
	localparam logic [ADDR_W-1:0] POT2_ADDR   = 4'd2;
	localparam logic [ADDR_W-1:0] POT3_ADDR   = 4'd3;
	localparam logic [ADDR_W-1:0] POT4_ADDR   = 4'd4;
	localparam logic [ADDR_W-1:0] POT5_ADDR   = 4'd5;
	localparam logic [ADDR_W-1:0] POT6_ADDR   = 4'd6;
	localparam logic [ADDR_W-1:0] POT7_ADDR   = 4'd7;
	localparam logic [ADDR_W-1:0] ALLPOT_ADDR = 4'd8;  // 1 = pot still counting
	localparam logic [ADDR_W-1:0] KBCODE_ADDR = 4'd9;
	localparam logic [ADDR_W-1:0] POTGO_ADDR  = 4'd11; // write only strobe
	localparam logic [ADDR_W-1:0] IRQ_ADDR    = 4'd14; // write irqen, read irqst
	localparam logic [ADDR_W-1:0] SKSTAT_ADDR = 4'd15;

	// skstat layout
	localparam int                SKSTAT_KEY_BIT = 2;     // key down flag, active low
	localparam logic [DATA_W-1:0] SKSTAT_UP      = 8'hFF; // no key held
	localparam logic [DATA_W-1:0] SKSTAT_DOWN    = 8'hFB; // key held, bit 2 clear

	localparam int KEY_IRQ_BIT = 6; // keyboard bit of irqen / irqst

	// pot timing
	localparam logic [DATA_W-1:0] POT_MAX     = 8'd228; // last count of a scan
	localparam int                DUMP_CYCLES = 16;     // pots held discharged

	// keyboard scan
	localparam int KEY_DWELL   = 4;                  // o2 cycles per key code
	localparam int KEY_DWELL_W = $clog2(KEY_DWELL);
	localparam int KEY_CODE_W  = 6;                  // 64 key matrix

	typedef enum logic [1:0] {
		owner_host,
		owner_key,
		owner_pot
	} bus_owner_e;

	typedef enum logic [1:0] {
		key_st_idle,
		key_st_compare, // first hit stored, waiting for the next scan
		key_st_held
	} key_state_e;

	typedef enum logic [1:0] {
		pot_st_idle,
		pot_st_dump,
		pot_st_count,
		pot_st_write
	} pot_state_e;

endpackage

/* source/bus_arbiter.sv */
module bus_arbiter (
	input  logic                         o2,
	input  logic                         arst_n,
	// outside host
	input  logic                         host_cyc,
	input  logic                         host_stb,
	input  logic                         host_we,
	input  logic [pokey_pkg::ADDR_W-1:0] host_adr,
	input  logic [pokey_pkg::DATA_W-1:0] host_dat_w,
	output logic [pokey_pkg::DATA_W-1:0] host_dat_r,
	output logic                         host_ack,
	// key scanner, writes only
	input  logic                         key_cyc,
	input  logic                         key_stb,
	input  logic [pokey_pkg::ADDR_W-1:0] key_adr,
	input  logic [pokey_pkg::DATA_W-1:0] key_dat,
	output logic                         key_ack,
	// pot scanner, writes only
	input  logic                         pot_cyc,
	input  logic                         pot_stb,
	input  logic [pokey_pkg::ADDR_W-1:0] pot_adr,
	input  logic [pokey_pkg::DATA_W-1:0] pot_dat,
	output logic                         pot_ack,
	// towards the register bank
	output logic                         bus_cyc,
	output logic                         bus_stb,
	output logic                         bus_we,
	output logic [pokey_pkg::ADDR_W-1:0] bus_adr,
	output logic [pokey_pkg::DATA_W-1:0] bus_dat_w,
	input  logic [pokey_pkg::DATA_W-1:0] bus_dat_r,
	input  logic                         bus_ack
);
	import pokey_pkg::*;

	bus_owner_e owner;   // master holding the grant
	logic       busy;    // grant outstanding until the bank acks
	logic       sel_cyc;
	logic       sel_stb;
	logic       host_req;
	logic       key_req;
	logic       pot_req;

	assign host_req = host_cyc & host_stb;
	assign key_req  = key_cyc & key_stb;
	assign pot_req  = pot_cyc & pot_stb;

	// fixed priority, decided only while the bus is free
	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			owner <= owner_host;
			busy  <= 1'b0;
		end else if (busy) begin
			if (bus_ack)
				busy <= 1'b0; // master drops stb next cycle, so no regrant
		end else if (host_req) begin
			owner <= owner_host;
			busy  <= 1'b1;
		end else if (key_req) begin
			owner <= owner_key;
			busy  <= 1'b1;
		end else if (pot_req) begin
			owner <= owner_pot;
			busy  <= 1'b1;
		end
	end

	always_comb begin
		case (owner)
			owner_key: begin
				sel_cyc   = key_cyc;
				sel_stb   = key_stb;
				bus_we    = 1'b1; // scanners only write
				bus_adr   = key_adr;
				bus_dat_w = key_dat;
			end
			owner_pot: begin
				sel_cyc   = pot_cyc;
				sel_stb   = pot_stb;
				bus_we    = 1'b1;
				bus_adr   = pot_adr;
				bus_dat_w = pot_dat;
			end
			default: begin
				sel_cyc   = host_cyc;
				sel_stb   = host_stb;
				bus_we    = host_we;
				bus_adr   = host_adr;
				bus_dat_w = host_dat_w;
			end
		endcase
	end

	assign bus_cyc = busy & sel_cyc;
	assign bus_stb = busy & sel_stb; // bank sees nothing until the grant is registered

	// ack goes back to the granted master only
	assign host_ack   = bus_ack & (owner == owner_host);
	assign key_ack    = bus_ack & (owner == owner_key);
	assign pot_ack    = bus_ack & (owner == owner_pot);
	assign host_dat_r = bus_dat_r; // valid with host_ack

endmodule

/* source/reg_bank.sv */
module reg_bank (
	input  logic                         o2,
	input  logic                         arst_n,
	input  logic                         bus_cyc,
	input  logic                         bus_stb,
	input  logic                         bus_we,
	input  logic [pokey_pkg::ADDR_W-1:0] bus_adr,
	input  logic [pokey_pkg::DATA_W-1:0] bus_dat_w,
	output logic [pokey_pkg::DATA_W-1:0] bus_dat_r,
	output logic                         bus_ack,
	output logic                         potgo,
	output logic                         irq_n
);
	import pokey_pkg::*;

	logic [DATA_W-1:0] pot_reg [8]; // POT0..POT7
	logic [DATA_W-1:0] allpot;
	logic [DATA_W-1:0] kbcode;
	logic              key_up;      // skstat bit 2
	logic [DATA_W-1:0] irqen;
	logic [DATA_W-1:0] irqst;
	logic [DATA_W-1:0] rd_mux;
	logic              req;         // fresh access this cycle
	logic              wr;

	assign req = bus_cyc & bus_stb & ~bus_ack; // stb is still up during the ack cycle
	assign wr  = req & bus_we;

	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			bus_ack <= 1'b0;
			potgo   <= 1'b0;
			for (int i = 0; i < 8; i++)
				pot_reg[i] <= '0;
			allpot  <= '0;
			kbcode  <= '0;
			key_up  <= 1'b1; // skstat reads FF
			irqen   <= '0;
			irqst   <= '0;
		end else begin
			bus_ack <= req;                              // one cycle after stb
			potgo   <= wr & (bus_adr == POTGO_ADDR);     // single cycle strobe
			if (wr) begin
				case (bus_adr)
					POT0_ADDR, POT1_ADDR, POT2_ADDR, POT3_ADDR,
					POT4_ADDR, POT5_ADDR, POT6_ADDR, POT7_ADDR:
						pot_reg[bus_adr[2:0]] <= bus_dat_w;
					ALLPOT_ADDR: allpot <= bus_dat_w;
					KBCODE_ADDR: kbcode <= bus_dat_w;
					IRQ_ADDR: begin
						irqen <= bus_dat_w;
						irqst <= irqst & bus_dat_w; // 0 bits acknowledge
					end
					SKSTAT_ADDR: begin
						key_up <= bus_dat_w[SKSTAT_KEY_BIT];
						if (!bus_dat_w[SKSTAT_KEY_BIT])
							irqst[KEY_IRQ_BIT] <= 1'b1; // new key down
					end
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		rd_mux = '1; // unmapped and write only addresses
		case (bus_adr)
			POT0_ADDR, POT1_ADDR, POT2_ADDR, POT3_ADDR,
			POT4_ADDR, POT5_ADDR, POT6_ADDR, POT7_ADDR:
				rd_mux = pot_reg[bus_adr[2:0]];
			ALLPOT_ADDR: rd_mux = allpot;
			KBCODE_ADDR: rd_mux = kbcode;
			IRQ_ADDR:    rd_mux = irqst;
			SKSTAT_ADDR: begin
				rd_mux                 = SKSTAT_UP;
				rd_mux[SKSTAT_KEY_BIT] = key_up;
			end
			default: ;
		endcase
	end

	// read data lines up with bus_ack
	always_ff @(posedge o2) begin
		if (req)
			bus_dat_r <= rd_mux;
	end

	assign irq_n = ~|(irqen & irqst);

endmodule

/* source/key_scanner.sv */
module key_scanner (
	input  logic                             o2,
	input  logic                             arst_n,
	output logic [pokey_pkg::KEY_CODE_W-1:0] key_scan_n,
	input  logic                             kr1_n,
	output logic                             key_cyc,
	output logic                             key_stb,
	output logic [pokey_pkg::ADDR_W-1:0]     key_adr,
	output logic [pokey_pkg::DATA_W-1:0]     key_dat,
	input  logic                             key_ack
);
	import pokey_pkg::*;

	key_state_e             state;
	logic [KEY_DWELL_W-1:0] dwell_cnt;  // cycles spent on the current code
	logic [KEY_CODE_W-1:0]  held_code;  // compare latch
	logic                   sk_pending; // skstat write queued behind kbcode
	logic                   sample;     // last cycle of the dwell
	logic                   hit;
	logic                   at_held;    // scan is back on the stored code

	assign sample  = (dwell_cnt == KEY_DWELL_W'(KEY_DWELL - 1));
	assign hit     = sample & ~kr1_n; // matrix answers low on a pressed key
	assign at_held = sample & (key_scan_n == held_code);

	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			state      <= key_st_idle;
			dwell_cnt  <= '0;
			key_scan_n <= '1; // 63
			held_code  <= '0;
			sk_pending <= 1'b0;
			key_cyc    <= 1'b0;
			key_stb    <= 1'b0;
			key_adr    <= '0;
			key_dat    <= '0;
		end else if (key_stb) begin
			// write in flight, whole scan frozen
			if (key_ack) begin
				key_cyc <= 1'b0;
				key_stb <= 1'b0;
			end
		end else if (sk_pending) begin
			// second half of a key press report
			key_cyc    <= 1'b1;
			key_stb    <= 1'b1;
			key_adr    <= SKSTAT_ADDR;
			key_dat    <= SKSTAT_DOWN;
			sk_pending <= 1'b0;
		end else begin
			if (sample) begin
				dwell_cnt  <= '0;
				key_scan_n <= key_scan_n - 1'b1; // wraps 0 -> 63
			end else begin
				dwell_cnt <= dwell_cnt + 1'b1;
			end

			case (state)
				key_st_idle: begin
					if (hit) begin
						held_code <= key_scan_n; // first hit
						state     <= key_st_compare;
					end
				end
				key_st_compare: begin
					if (at_held) begin
						if (hit) begin
							// same key one scan later, report it
							state      <= key_st_held;
							key_cyc    <= 1'b1;
							key_stb    <= 1'b1;
							key_adr    <= KBCODE_ADDR;
							key_dat    <= DATA_W'(held_code);
							sk_pending <= 1'b1;
						end else begin
							state <= key_st_idle; // bounce
						end
					end
				end
				key_st_held: begin
					// full scan came round without the key
					if (at_held && !hit) begin
						state   <= key_st_idle;
						key_cyc <= 1'b1;
						key_stb <= 1'b1;
						key_adr <= SKSTAT_ADDR;
						key_dat <= SKSTAT_UP;
					end
				end
				default: state <= key_st_idle;
			endcase
		end
	end

endmodule

/* source/pot_scanner.sv */
module pot_scanner (
	input  logic                         o2,
	input  logic                         arst_n,
	input  logic                         potgo,
	input  logic [7:0]                   pot_line,
	output logic                         pot_dump,
	output logic                         pot_cyc,
	output logic                         pot_stb,
	output logic [pokey_pkg::ADDR_W-1:0] pot_adr,
	output logic [pokey_pkg::DATA_W-1:0] pot_dat,
	input  logic                         pot_ack
);
	import pokey_pkg::*;

	pot_state_e        state;
	logic [DATA_W-1:0] cnt;         // dump timer, then the pot counter
	logic [DATA_W-1:0] pot_val [8]; // latched counts
	logic [7:0]        done;        // line has already risen
	logic [3:0]        widx;        // next result, 8 is allpot, 9 is finished

	always_ff @(posedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			state    <= pot_st_idle;
			cnt      <= '0;
			done     <= '0;
			widx     <= '0;
			pot_dump <= 1'b0;
			pot_cyc  <= 1'b0;
			pot_stb  <= 1'b0;
			pot_adr  <= '0;
			pot_dat  <= '0;
		end else begin
			if (pot_stb && pot_ack) begin
				pot_cyc <= 1'b0;
				pot_stb <= 1'b0;
			end

			case (state)
				pot_st_idle: begin
					if (potgo && !pot_stb) begin
						state    <= pot_st_dump;
						pot_dump <= 1'b1; // discharge the caps
						cnt      <= '0;
						done     <= '0;
						pot_cyc  <= 1'b1;
						pot_stb  <= 1'b1;
						pot_adr  <= ALLPOT_ADDR;
						pot_dat  <= '1; // all pots counting
					end
				end
				pot_st_dump: begin
					if (cnt == DATA_W'(DUMP_CYCLES - 1)) begin
						pot_dump <= 1'b0;
						cnt      <= '0;
						state    <= pot_st_count;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				pot_st_count: begin
					// keeps counting even if the allpot write is still waiting
					done <= done | pot_line;
					if (cnt == POT_MAX) begin
						state <= pot_st_write;
						widx  <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				pot_st_write: begin
					if (!pot_stb) begin
						if (widx == 4'd9) begin
							state <= pot_st_idle; // allpot 0 acked
						end else begin
							pot_cyc <= 1'b1;
							pot_stb <= 1'b1;
							pot_adr <= (widx == 4'd8) ? ALLPOT_ADDR : POT0_ADDR + widx;
							pot_dat <= (widx == 4'd8) ? '0 : pot_val[widx[2:0]];
							widx    <= widx + 1'b1;
						end
					end
				end
				default: state <= pot_st_idle;
			endcase
		end
	end

	// first rising cycle wins, lines still low at the end get POT_MAX
	always_ff @(posedge o2) begin
		if (state == pot_st_count) begin
			for (int i = 0; i < 8; i++) begin
				if (!done[i] && (pot_line[i] || cnt == POT_MAX))
					pot_val[i] <= cnt;
			end
		end
	end

endmodule

/* source/pokey_top.sv */
module pokey_top (
	input  logic                             o2,     // phase 2 clock
	input  logic                             arst_n,
	// host wishbone slave port
	input  logic                             host_cyc,
	input  logic                             host_stb,
	input  logic                             host_we,
	input  logic [pokey_pkg::ADDR_W-1:0]     host_adr,
	input  logic [pokey_pkg::DATA_W-1:0]     host_dat_w,
	output logic [pokey_pkg::DATA_W-1:0]     host_dat_r,
	output logic                             host_ack,
	// controller side
	output logic [pokey_pkg::KEY_CODE_W-1:0] key_scan_n,
	input  logic                             kr1_n,
	input  logic [7:0]                       pot_line,
	output logic                             pot_dump,
	output logic                             irq_n
);
	import pokey_pkg::*;

	// key scanner master
	logic              key_cyc;
	logic              key_stb;
	logic [ADDR_W-1:0] key_adr;
	logic [DATA_W-1:0] key_dat;
	logic              key_ack;
	// pot scanner master
	logic              pot_cyc;
	logic              pot_stb;
	logic [ADDR_W-1:0] pot_adr;
	logic [DATA_W-1:0] pot_dat;
	logic              pot_ack;
	// shared bus, owner kept as bus_owner_e inside the arbiter
	logic              bus_cyc;
	logic              bus_stb;
	logic              bus_we;
	logic [ADDR_W-1:0] bus_adr;
	logic [DATA_W-1:0] bus_dat_w;
	logic [DATA_W-1:0] bus_dat_r;
	logic              bus_ack;
	logic              potgo;   // bank -> pot scanner

	bus_arbiter bus_arbiter_inst (
		.o2(o2), .arst_n(arst_n),
		.host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we),
		.host_adr(host_adr), .host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r), .host_ack(host_ack),
		.key_cyc(key_cyc), .key_stb(key_stb), .key_adr(key_adr),
		.key_dat(key_dat), .key_ack(key_ack),
		.pot_cyc(pot_cyc), .pot_stb(pot_stb), .pot_adr(pot_adr),
		.pot_dat(pot_dat), .pot_ack(pot_ack),
		.bus_cyc(bus_cyc), .bus_stb(bus_stb), .bus_we(bus_we),
		.bus_adr(bus_adr), .bus_dat_w(bus_dat_w),
		.bus_dat_r(bus_dat_r), .bus_ack(bus_ack)
	);

	reg_bank reg_bank_inst (
		.o2(o2), .arst_n(arst_n),
		.bus_cyc(bus_cyc), .bus_stb(bus_stb), .bus_we(bus_we),
		.bus_adr(bus_adr), .bus_dat_w(bus_dat_w),
		.bus_dat_r(bus_dat_r), .bus_ack(bus_ack),
		.potgo(potgo), .irq_n(irq_n)
	);

	key_scanner key_scanner_inst (
		.o2(o2), .arst_n(arst_n),
		.key_scan_n(key_scan_n), .kr1_n(kr1_n),
		.key_cyc(key_cyc), .key_stb(key_stb), .key_adr(key_adr),
		.key_dat(key_dat), .key_ack(key_ack)
	);

	pot_scanner pot_scanner_inst (
		.o2(o2), .arst_n(arst_n),
		.potgo(potgo), .pot_line(pot_line), .pot_dump(pot_dump),
		.pot_cyc(pot_cyc), .pot_stb(pot_stb), .pot_adr(pot_adr),
		.pot_dat(pot_dat), .pot_ack(pot_ack)
	);

endmodule

/* bench/controller_model.sv */
module controller_model (
	input  logic            o2,
	input  logic            arst_n,
	input  logic [5:0]      key_scan_n, // code currently driven by the scanner
	input  logic            key_down,   // one key of the matrix is held
	input  logic [5:0]      key_code,
	output logic            kr1_n,
	input  logic            pot_dump,
	input  logic [7:0][7:0] pot_target, // cycles from dump release to line high
	output logic [7:0]      pot_line
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [8:0] elapsed; // cycles since the caps were released, saturates
	logic       armed;   // a dump has been seen since reset

	// everything changes on the falling edge, the DUT samples on the rising one
	always @(negedge o2 or negedge arst_n) begin
		if (!arst_n) begin
			kr1_n    <= 1'b1;
			pot_line <= '0;
			elapsed  <= '0;
			armed    <= 1'b0;
		end else begin
			kr1_n <= !(key_down && key_scan_n == key_code); // matrix answers low

			if (pot_dump) begin
				// caps held discharged
				pot_line <= '0;
				elapsed  <= '0;
				armed    <= 1'b1;
			end else if (armed) begin
				for (int i = 0; i < 8; i++)
					pot_line[i] <= (elapsed >= {1'b0, pot_target[i]}); // stays high once up
				if (elapsed != 9'h1FF)
					elapsed <= elapsed + 9'd1;
			end
		end
	end

endmodule

/* bench/pokey_tb.sv */
module pokey_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pokey_pkg::*;

	localparam int ROW       = 12;                      // op, a, b, c, eight pot targets
	localparam int MAX_STEPS = 32;
	localparam int KEY_BOUND = 2 * 64 * KEY_DWELL + 64; // two full scans plus bus waits
	localparam int POT_BOUND = DUMP_CYCLES + int'(POT_MAX) + 9 * 4 + 64;
	localparam logic [DATA_W-1:0] KEY_FLAG = 8'h04;     // skstat bit 2, low while a key is down
	localparam logic [DATA_W-1:0] SK_IDLE  = 8'hFF;

	logic              o2 = 1'b0;
	logic              arst_n;
	logic              host_cyc;
	logic              host_stb;
	logic              host_we;
	logic [ADDR_W-1:0] host_adr;
	logic [DATA_W-1:0] host_dat_w;
	logic [DATA_W-1:0] host_dat_r;
	logic              host_ack;
	logic [5:0]        key_scan_n;
	logic              kr1_n;
	logic [7:0]        pot_line;
	logic              pot_dump;
	logic              irq_n;
	logic              key_down;   // controller model stimulus
	logic [5:0]        key_code;
	logic [7:0][7:0]   pot_target;

	logic [7:0]        test_mem [MAX_STEPS*ROW];
	logic [31:0]       rng_state    = 32'd70427;
	int                cycle        = 0;
	int                cycle_limit  = 0;
	int                errors       = 0;
	int                tests_run    = 0;
	int                tests_failed = 0;
	logic [DATA_W-1:0] irqen_shadow = '0;      // last value written to IRQEN
	string             cur_desc     = "reset";

	always #4 o2 = ~o2; // 8 ns period

	pokey_top pokey_top_inst (
		.o2(o2), .arst_n(arst_n),
		.host_cyc(host_cyc), .host_stb(host_stb), .host_we(host_we),
		.host_adr(host_adr), .host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r), .host_ack(host_ack),
		.key_scan_n(key_scan_n), .kr1_n(kr1_n),
		.pot_line(pot_line), .pot_dump(pot_dump), .irq_n(irq_n)
	);

	controller_model controller_inst (
		.o2(o2), .arst_n(arst_n),
		.key_scan_n(key_scan_n), .key_down(key_down), .key_code(key_code), .kr1_n(kr1_n),
		.pot_dump(pot_dump), .pot_target(pot_target), .pot_line(pot_line)
	);

	// run limit, checked every rising edge
	always @(posedge o2) begin
		cycle = cycle + 1;
		if (cycle_limit > 0 && cycle > cycle_limit) begin
			$display("timeout: %s did not finish within the %0d cycle limit", cur_desc,
				cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic string op_name(input logic [7:0] op);
		case (op)
			8'h01:   return "reset check";
			8'h02:   return "key press";
			8'h03:   return "key release";
			8'h04:   return "pot scan";
			8'h05:   return "key interrupt";
			default: return "unknown op";
		endcase
	endfunction

	// worst case cycles for one step, 32 covers gaps and extra reads
	function automatic int step_bound(input logic [7:0] op, input logic [7:0] flag);
		case (op)
			8'h01:        return 16 * 4 + 32;
			8'h02, 8'h03: return KEY_BOUND + 32;
			8'h04:        return POT_BOUND + ((flag != 8'h00) ? 2 * KEY_BOUND : 0) + 32;
			8'h05:        return 2 * KEY_BOUND + 64;
			default:      return 32;
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [DATA_W-1:0] got,
	                               input logic [DATA_W-1:0] want);
		$display("ERROR %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, want);
		errors++;
	endtask

	// one wishbone classic transfer, inputs change on the falling edge
	task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] adr,
	                        input logic [DATA_W-1:0] wdat, input int max_cyc,
	                        output logic [DATA_W-1:0] rdat);
		int cycles;
		@(negedge o2);
		host_cyc   = 1'b1;
		host_stb   = 1'b1;
		host_we    = we;
		host_adr   = adr;
		host_dat_w = wdat;
		cycles     = 0;
		do begin
			@(negedge o2);
			cycles++;
		end while (!host_ack);
		rdat     = host_dat_r;
		host_cyc = 1'b0; // drop right after the ack
		host_stb = 1'b0;
		host_we  = 1'b0;
		if (cycles < 2 || cycles > max_cyc) begin
			$display("ERROR %0t: host access to 0x%0h took %0d cycles, expected 2 to %0d",
				$time, adr, cycles, max_cyc);
			errors++;
		end
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] rd);
		bus_xfer(1'b0, adr, '0, 4, rd);
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
		logic [DATA_W-1:0] unused_rd;
		bus_xfer(1'b1, adr, dat, 4, unused_rd);
	endtask

	task automatic random_read();
		logic [31:0]       r;
		logic [DATA_W-1:0] rd;
		r = xorshift();
		read_reg(r[3:0], rd); // only the handshake is of interest
	endtask

	// read until the masked value matches or the bound runs out
	task automatic poll_reg(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] mask,
	                        input logic [DATA_W-1:0] val, input int bound, input bit mix,
	                        output logic [DATA_W-1:0] rd, output bit ok);
		int          start;
		logic [31:0] r;
		start = cycle;
		do begin
			@(negedge o2); // one free bus slot so a waiting scanner gets the grant
			r = xorshift();
			if (mix && r[0])
				random_read(); // extra traffic against the scanners
			read_reg(adr, rd);
			ok = ((rd & mask) == val);
		end while (!ok && cycle - start <= bound);
	endtask

	task automatic expect_key_press(input logic [7:0] code, input logic [7:0] exp_kb,
	                                input logic [7:0] exp_sk);
		logic [DATA_W-1:0] rd;
		bit                ok;
		key_state_e        want;
		want = key_st_held;
		poll_reg(SKSTAT_ADDR, KEY_FLAG, 8'h00, KEY_BOUND, 1'b1, rd, ok);
		if (!ok) begin
			$display("key 0x%02h was never reported, scanner did not reach %s in %0d cycles",
				code, want.name(), KEY_BOUND);
			errors++;
		end
		if (rd !== exp_sk)
			report_mismatch("SKSTAT", rd, exp_sk);
		read_reg(KBCODE_ADDR, rd);
		if (rd !== exp_kb)
			report_mismatch("KBCODE", rd, exp_kb);
	endtask

	task automatic expect_key_release(input logic [7:0] exp_kb, input logic [7:0] exp_sk);
		logic [DATA_W-1:0] rd;
		bit                ok;
		key_state_e        want;
		want = key_st_idle;
		poll_reg(SKSTAT_ADDR, KEY_FLAG, KEY_FLAG, KEY_BOUND, 1'b1, rd, ok);
		if (!ok) begin
			$display("key release never showed, scanner did not return to %s in %0d cycles",
				want.name(), KEY_BOUND);
			errors++;
		end
		if (rd !== exp_sk)
			report_mismatch("SKSTAT", rd, exp_sk);
		read_reg(KBCODE_ADDR, rd);
		if (rd !== exp_kb)
			report_mismatch("KBCODE after release", rd, exp_kb); // last code stays
	endtask

	initial begin
		int                n_steps;
		int                base;
		int                err_before;
		int                waited;
		logic [31:0]       r;
		logic [7:0]        op;
		logic [7:0]        a;
		logic [7:0]        b;
		logic [7:0]        c;
		logic [7:0]        t;
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] want;
		bit                ok;

		arst_n     = 1'b0;
		host_cyc   = 1'b0;
		host_stb   = 1'b0;
		host_we    = 1'b0;
		host_adr   = '0;
		host_dat_w = '0;
		key_down   = 1'b0;
		key_code   = '0;
		pot_target = '1; // no line rises

		for (int i = 0; i < MAX_STEPS * ROW; i++)
			test_mem[i] = 8'h00;
		$readmemh("bench/pokey_tests.txt", test_mem);
		n_steps = 0;
		cycle_limit = 8 + 2000;
		while (n_steps < MAX_STEPS && test_mem[n_steps*ROW] != 8'h00) begin
			cycle_limit += step_bound(test_mem[n_steps*ROW], test_mem[n_steps*ROW+2]);
			n_steps++;
		end
		if (n_steps == 0) begin
			$display("no test steps were read from bench/pokey_tests.txt");
			errors++;
		end

		repeat (8) @(negedge o2);
		// scan starts at code 63, caps not dumped, no ack
		if (key_scan_n !== 6'h3F || pot_dump !== 1'b0 || host_ack !== 1'b0) begin
			$display("ERROR %0t: in reset key_scan_n 0x%02h, pot_dump %b, host_ack %b",
				$time, key_scan_n, pot_dump, host_ack);
			errors++;
		end
		arst_n = 1'b1;

		for (int s = 0; s < n_steps; s++) begin
			base = s * ROW;
			op   = test_mem[base];
			a    = test_mem[base+1];
			b    = test_mem[base+2];
			c    = test_mem[base+3];
			r    = xorshift();
			repeat (r[2:0]) @(negedge o2); // idle gap
			repeat (r[4:3]) random_read();
			cur_desc   = $sformatf("test %0d (%s)", s + 1, op_name(op));
			err_before = errors;

			case (op)
				8'h01: begin
					// a: data regs, b: SKSTAT, c: unmapped
					for (int i = 0; i < 16; i++) begin
						if (i != int'(POTGO_ADDR)) begin
							bus_xfer(1'b0, ADDR_W'(i), '0, 2, rd); // idle bus, exactly 2
							if (i == int'(SKSTAT_ADDR))
								want = b;
							else if (i == 10 || i == 12 || i == 13)
								want = c;
							else
								want = a;
							if (rd !== want)
								report_mismatch($sformatf("register 0x%0h", i), rd, want);
						end
					end
					if (irq_n !== 1'b1) begin
						$display("ERROR %0t: irq_n is low after reset", $time);
						errors++;
					end
				end
				8'h02: begin
					@(negedge o2);
					key_code = a[5:0];
					key_down = 1'b1;
					expect_key_press(a, b, c);
					if (irq_n !== 1'b1 && !irqen_shadow[KEY_IRQ_BIT]) begin
						$display("ERROR %0t: irq_n low with the key interrupt disabled", $time);
						errors++;
					end
				end
				8'h03: begin
					@(negedge o2);
					key_down = 1'b0;
					expect_key_release(a, b);
				end
				8'h04: begin
					@(negedge o2);
					for (int i = 0; i < 8; i++)
						pot_target[i] = test_mem[base+4+i];
					if (b != 8'h00) begin
						key_code = a[5:0]; // key activity during the scan
						key_down = 1'b1;
					end
					write_reg(POTGO_ADDR, 8'h00);
					poll_reg(ALLPOT_ADDR, 8'hFF, 8'hFF, 32, 1'b0, rd, ok);
					if (!ok) begin
						$display("ALLPOT never showed the pots counting after POTGO");
						errors++;
					end
					poll_reg(ALLPOT_ADDR, 8'hFF, 8'h00, POT_BOUND, 1'b1, rd, ok);
					if (!ok) begin
						$display("pot scan never finished, ALLPOT still 0x%02h after %0d cycles",
							rd, POT_BOUND);
						errors++;
					end
					for (int i = 0; i < 8; i++) begin
						t    = pot_target[i];
						want = (t > POT_MAX) ? POT_MAX : t; // late lines clamp
						read_reg(ADDR_W'(i), rd);
						if (rd !== want)
							report_mismatch($sformatf("POT%0d", i), rd, want);
					end
					if (b != 8'h00) begin
						expect_key_press(a, a, c);
						@(negedge o2);
						key_down = 1'b0;
						expect_key_release(a, SK_IDLE);
					end
				end
				8'h05: begin
					write_reg(IRQ_ADDR, 8'h00); // clears old status
					write_reg(IRQ_ADDR, a);
					irqen_shadow = a;
					if (irq_n !== 1'b1) begin
						$display("ERROR %0t: irq_n low before any key was pressed", $time);
						errors++;
					end
					@(negedge o2);
					key_code = b[5:0];
					key_down = 1'b1;
					waited   = 0;
					while (irq_n && waited < KEY_BOUND) begin
						@(negedge o2);
						waited++;
					end
					if (irq_n) begin
						$display("irq_n stayed high for %0d cycles after the key press", waited);
						errors++;
					end
					read_reg(IRQ_ADDR, rd);
					if (rd !== c)
						report_mismatch("IRQST", rd, c);
					read_reg(KBCODE_ADDR, rd);
					if (rd !== b)
						report_mismatch("KBCODE", rd, b);
					@(negedge o2);
					key_down = 1'b0;
					expect_key_release(b, SK_IDLE);
					write_reg(IRQ_ADDR, 8'h00);
					irqen_shadow = '0;
					if (irq_n !== 1'b1) begin
						$display("ERROR %0t: irq_n still low after writing 0 to IRQ", $time);
						errors++;
					end
				end
				default: begin
					$display("%s has opcode 0x%02h, which is not known", cur_desc, op);
					errors++;
				end
			endcase

			tests_run++;
			if (errors == err_before) begin
				$display("%s passed", cur_desc);
			end else begin
				tests_failed++;
				$display("%s failed with %0d errors", cur_desc, errors - err_before);
			end
		end

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* bench/pokey_tests.txt */
// columns (hex): op a b c p0 p1 p2 p3 p4 p5 p6 p7, one step per line, op 00 ends
// 01 reset: a data regs, b skstat, c unmapped | 02 press: a code, b kbcode, c skstat
// 03 release: a kbcode, b skstat | 04 potgo: a code, b press flag, c skstat, p pot counts
// 05 irq: a irqen, b code, c irqst
01 00 ff ff 00 00 00 00 00 00 00 00
02 2a 2a fb 00 00 00 00 00 00 00 00
03 2a ff 00 00 00 00 00 00 00 00 00
02 05 05 fb 00 00 00 00 00 00 00 00
03 05 ff 00 00 00 00 00 00 00 00 00
02 3f 3f fb 00 00 00 00 00 00 00 00
03 3f ff 00 00 00 00 00 00 00 00 00
02 00 00 fb 00 00 00 00 00 00 00 00
03 00 ff 00 00 00 00 00 00 00 00 00
04 00 00 fb 10 40 80 e4 f0 ff 00 c8
04 11 01 fb 05 20 60 a0 ff e3 30 02
05 40 1c 40 00 00 00 00 00 00 00 00
02 21 21 fb 00 00 00 00 00 00 00 00
03 21 ff 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00

/* flist.f */
source/pokey_pkg.sv
source/bus_arbiter.sv
source/reg_bank.sv
source/key_scanner.sv
source/pot_scanner.sv
source/pokey_top.sv
bench/controller_model.sv
bench/pokey_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the POKEY input testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ps -f flist.f --top-module pokey_tb -o pokey_sim \
	&& ./obj_dir/pokey_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation FAILED"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }
